// ==== chess_pkg.sv ====
`default_nettype none

package chess_pkg;

   typedef logic [3:0]          piece_t;
   typedef logic [255:0]        board_t;
   typedef logic [63:0]         bitboard_t;
   typedef logic signed [15:0]  score_t;
   typedef logic [7:0]          reg_addr_t;
   typedef logic [31:0]         reg_data_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
      reg_data_t data;
   } wr_req_t;

   typedef struct packed {
      logic   busy;
      logic   valid;
      score_t score;
   } eval_res_t;

   // Piece kinds in the low 3 bits of a square
   localparam logic [2:0] KIND_EMPTY  = 3'd0;
   localparam logic [2:0] KIND_PAWN   = 3'd1;
   localparam logic [2:0] KIND_KNIGHT = 3'd2;
   localparam logic [2:0] KIND_BISHOP = 3'd3;
   localparam logic [2:0] KIND_ROOK   = 3'd4;
   localparam logic [2:0] KIND_QUEEN  = 3'd5;
   localparam logic [2:0] KIND_KING   = 3'd6;
   localparam int         BLACK_BIT   = 3;      // Colour flag in piece_t

   localparam score_t PAWN_VAL   = 16'sd100;
   localparam score_t KNIGHT_VAL = 16'sd320;
   localparam score_t BISHOP_VAL = 16'sd330;
   localparam score_t ROOK_VAL   = 16'sd500;
   localparam score_t QUEEN_VAL  = 16'sd900;
   localparam score_t KING_VAL   = 16'sd0;

   localparam reg_addr_t REG_CTRL    = 8'd0;
   localparam reg_addr_t REG_STATUS  = 8'd1;
   localparam reg_addr_t REG_SCORE   = 8'd2;
   localparam reg_addr_t REG_ROW0    = 8'd8;
   localparam reg_addr_t REG_ROW7    = 8'd15;
   localparam reg_addr_t REG_WATT_LO = 8'd16;
   localparam reg_addr_t REG_WATT_HI = 8'd17;
   localparam reg_addr_t REG_BATT_LO = 8'd18;
   localparam reg_addr_t REG_BATT_HI = 8'd19;

   localparam int CTRL_START_BIT    = 0;
   localparam int CTRL_SOFT_RST_BIT = 31;
   localparam int STATUS_BUSY_BIT   = 0;
   localparam int STATUS_VALID_BIT  = 1;

   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== axil_write.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_write
   import chess_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [31:0] awaddr,
   input  wire logic        awvalid,
   output logic             awready,
   input  wire reg_data_t   wdata,
   input  wire logic        wvalid,
   output logic             wready,
   output logic [1:0]       bresp,
   output logic             bvalid,
   input  wire logic        bready,
   output wr_req_t          wr
);

   logic accept;

   // Address and data arrive held, so one handshake takes both
   assign accept = awready && awvalid && wvalid;
   assign wready = awready;
   assign bresp  = AXI_RESP_OKAY;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         awready  <= 1'b0;
         bvalid   <= 1'b0;
         wr.valid <= 1'b0;
      end
      else
      begin
         awready  <= awvalid && wvalid && !bvalid && !awready;   // One-cycle pulse
         wr.valid <= accept;
         if (accept)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
      end

      if (accept)
      begin
         wr.addr <= awaddr[9:2];                                  // Word address
         wr.data <= wdata;
      end
   end

   a_no_accept_in_resp: assert property (
      @(posedge clk) disable iff (rst)
      bvalid |-> !awready
   );

   a_wr_single_pulse: assert property (
      @(posedge clk) disable iff (rst)
      wr.valid |=> !wr.valid
   );

endmodule

`default_nettype wire

// ==== ctrl_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs
   import chess_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire wr_req_t     wr,
   input  wire logic [31:0] araddr,
   input  wire logic        arvalid,
   output logic             arready,
   output reg_data_t        rdata,
   output logic [1:0]       rresp,
   output logic             rvalid,
   input  wire logic        rready,
   input  wire eval_res_t   eval_res,
   input  wire bitboard_t   white_att,
   input  wire bitboard_t   black_att,
   output board_t           board,
   output logic             start_eval,
   output logic             soft_reset
);

   reg_addr_t rd_addr;
   reg_data_t rd_word;
   reg_data_t status_word;
   logic      ctrl_hit;
   logic      row_hit;
   logic [2:0] wr_row;

   assign arready = 1'b1;           // Always ready
   assign rresp   = AXI_RESP_OKAY;

   assign rd_addr  = araddr[9:2];
   assign ctrl_hit = wr.valid && (wr.addr == REG_CTRL);
   assign row_hit  = wr.valid && (wr.addr >= REG_ROW0) && (wr.addr <= REG_ROW7);
   assign wr_row   = wr.addr[2:0];

   // Control pulses, one cycle after the write strobe
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         start_eval <= 1'b0;
         soft_reset <= 1'b0;
      end
      else
      begin
         start_eval <= ctrl_hit && wr.data[CTRL_START_BIT];
         soft_reset <= ctrl_hit && wr.data[CTRL_SOFT_RST_BIT];
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || soft_reset)
         board <= '0;                                  // All squares empty
      else if (row_hit)
         board[{wr_row, 5'd0} +: 32] <= wr.data;
   end

   always_comb
   begin
      status_word                   = '0;
      status_word[STATUS_BUSY_BIT]  = eval_res.busy;
      status_word[STATUS_VALID_BIT] = eval_res.valid;
   end

   always_comb
   begin
      case (rd_addr) inside
         REG_STATUS:
            rd_word = status_word;
         REG_SCORE:
            rd_word = {{16{eval_res.score[15]}}, eval_res.score};
         [REG_ROW0:REG_ROW7]:
            rd_word = board[{rd_addr[2:0], 5'd0} +: 32];
         REG_WATT_LO:
            rd_word = white_att[31:0];
         REG_WATT_HI:
            rd_word = white_att[63:32];
         REG_BATT_LO:
            rd_word = black_att[31:0];
         REG_BATT_HI:
            rd_word = black_att[63:32];
         default:
            rd_word = '0;                              // CTRL and unmapped
      endcase
   end

   // Read response, one read in flight
   always_ff @(posedge clk)
   begin
      if (rst)
         rvalid <= 1'b0;
      else if (arvalid)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;

      if (arvalid)
         rdata <= rd_word;
   end

   a_no_pulse_in_rst: assert property (
      @(posedge clk)
      start_eval || soft_reset |-> !rst
   );

endmodule

`default_nettype wire

// ==== material_eval.sv ====
`timescale 1ns/1ns
`default_nettype none

module material_eval
   import chess_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   rst,
   input  wire board_t board,
   input  wire logic   start,
   input  wire logic   clear,
   output eval_res_t   res
);

   typedef enum logic {IDLE, SCAN} state_t;

   state_t     state;
   logic [5:0] sq;
   score_t     acc;
   score_t     sq_val;
   piece_t     piece;

   function automatic score_t kind_value(input logic [2:0] kind);
      case (kind)
         KIND_PAWN:   return PAWN_VAL;
         KIND_KNIGHT: return KNIGHT_VAL;
         KIND_BISHOP: return BISHOP_VAL;
         KIND_ROOK:   return ROOK_VAL;
         KIND_QUEEN:  return QUEEN_VAL;
         KIND_KING:   return KING_VAL;
         default:     return '0;                       // Empty or code 7
      endcase
   endfunction

   assign piece  = board[{sq, 2'b00} +: 4];
   assign sq_val = piece[BLACK_BIT] ? -kind_value(piece[2:0]) : kind_value(piece[2:0]);

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         state <= IDLE;
         res   <= '0;
      end
      else if (start)
      begin
         state     <= SCAN;                            // Restarts a running scan
         res.busy  <= 1'b1;
         res.valid <= 1'b0;
      end
      else if (state == SCAN && sq == 6'd63)
      begin
         state     <= IDLE;
         res.busy  <= 1'b0;
         res.valid <= 1'b1;
         res.score <= acc + sq_val;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         sq  <= '0;
         acc <= '0;
      end
      else if (state == SCAN)
      begin
         sq  <= sq + 6'd1;
         acc <= acc + sq_val;
      end
   end

   a_busy_xor_valid: assert property (
      @(posedge clk) disable iff (rst)
      !(res.busy && res.valid)
   );

endmodule

`default_nettype wire

// ==== pawn_attacks.sv ====
`timescale 1ns/1ns
`default_nettype none

module pawn_attacks
   import chess_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   rst,
   input  wire board_t board,
   output bitboard_t   white_att,
   output bitboard_t   black_att
);

   bitboard_t white_nxt;
   bitboard_t black_nxt;

   always_comb
   begin
      piece_t p;
      white_nxt = '0;
      black_nxt = '0;
      for (int s = 0; s < 64; s++)
      begin
         p = board[4*s +: 4];
         if (p[2:0] == KIND_PAWN && !p[BLACK_BIT] && s / 8 < 7)
         begin
            if (s % 8 > 0)
               white_nxt[s+7] = 1'b1;                  // Up and left
            if (s % 8 < 7)
               white_nxt[s+9] = 1'b1;                  // Up and right
         end
         if (p[2:0] == KIND_PAWN && p[BLACK_BIT] && s / 8 > 0)
         begin
            if (s % 8 > 0)
               black_nxt[s-9] = 1'b1;
            if (s % 8 < 7)
               black_nxt[s-7] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         white_att <= '0;
         black_att <= '0;
      end
      else
      begin
         white_att <= white_nxt;
         black_att <= black_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== chess_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module chess_core_top
   import chess_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [31:0] awaddr,
   input  wire logic        awvalid,
   output logic             awready,
   input  wire reg_data_t   wdata,
   input  wire logic        wvalid,
   output logic             wready,
   output logic [1:0]       bresp,
   output logic             bvalid,
   input  wire logic        bready,
   input  wire logic [31:0] araddr,
   input  wire logic        arvalid,
   output logic             arready,
   output reg_data_t        rdata,
   output logic [1:0]       rresp,
   output logic             rvalid,
   input  wire logic        rready
);

   wr_req_t   wr;
   board_t    board;
   eval_res_t eval_res;
   bitboard_t white_att;
   bitboard_t black_att;
   logic      start_eval;
   logic      soft_reset;

   axil_write u_axil_write (
      .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
      .bresp, .bvalid, .bready, .wr
   );

   ctrl_regs u_ctrl_regs (
      .clk, .rst, .wr, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid,
      .rready, .eval_res, .white_att, .black_att, .board, .start_eval, .soft_reset
   );

   material_eval u_material_eval (
      .clk,
      .rst,
      .board,
      .start (start_eval),
      .clear (soft_reset),                             // Soft reset wipes the result
      .res   (eval_res)
   );

   pawn_attacks u_pawn_attacks (
      .clk, .rst, .board, .white_att, .black_att
   );

endmodule

`default_nettype wire

// ==== chess_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module chess_tb
   import chess_pkg::*;
();

   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_EVAL, OP_ATTACK} op_t;

   typedef struct packed {
      op_t       op;
      reg_addr_t addr;
      reg_data_t data;
      bitboard_t exp;
   } step_t;

   localparam int LIMIT = 200;

   logic        clk, rst;
   logic [31:0] awaddr, araddr;
   reg_data_t   wdata, rdata;
   logic        awvalid, awready, wvalid, wready;
   logic        bvalid, bready, arvalid, arready, rvalid, rready;
   logic [1:0]  bresp, rresp;

   step_t       steps[$];
   string       names[$];
   int          tests = 0;
   int          errors = 0;
   int          proto_errs = 0;
   int unsigned seed = 32'hea43_ea10;

   chess_core_top uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int square_value(input logic [3:0] code);
      int v;
      case (code[2:0])
         3'd1: v = 100;
         3'd2: v = 320;
         3'd3: v = 330;
         3'd4: v = 500;
         3'd5: v = 900;
         default: v = 0;                                // King, empty and code 7
      endcase
      return code[3] ? -v : v;
   endfunction

   function automatic reg_data_t ref_score(input board_t bd);
      int          sum;
      logic [15:0] s16;
      sum = 0;
      for (int s = 0; s < 64; s++)
         sum += square_value(bd[4*s +: 4]);
      s16 = sum[15:0];
      return {{16{s16[15]}}, s16};
   endfunction

   function automatic bitboard_t ref_attacks(input board_t bd, input logic black);
      bitboard_t  m;
      int         dir;
      logic [3:0] code;
      m   = '0;
      dir = black ? -1 : 1;                             // Black pawns move toward rank 0
      for (int r = 0; r < 8; r++)
         for (int f = 0; f < 8; f++)
         begin
            code = bd[4*(8*r + f) +: 4];
            if (code == {black, 3'd1} && r + dir >= 0 && r + dir <= 7)
            begin
               if (f > 0)
                  m[8*(r + dir) + f - 1] = 1'b1;
               if (f < 7)
                  m[8*(r + dir) + f + 1] = 1'b1;
            end
         end
      return m;
   endfunction

   function automatic board_t random_board(input logic pawns_only);
      board_t      bd;
      logic [31:0] r32;
      for (int s = 0; s < 64; s++)
      begin
         r32 = $urandom;
         bd[4*s +: 4] = r32[3:0];
         if (pawns_only)
            bd[4*s +: 4] = r32[1] ? {r32[0], 3'd1} : 4'd0;
      end
      return bd;
   endfunction

   function automatic void add_step(input op_t op, input reg_addr_t a, input reg_data_t d,
                                    input bitboard_t e, input string name);
      step_t s;
      s.op   = op;
      s.addr = a;
      s.data = d;
      s.exp  = e;
      steps.push_back(s);
      names.push_back(name);
   endfunction

   function automatic void add_board(input board_t bd);
      for (int r = 0; r < 8; r++)
         add_step(OP_WRITE, REG_ROW0 + r[7:0], bd[32*r +: 32], '0, "");
   endfunction

   function automatic void add_attack_checks(input board_t bd, input string tag);
      add_step(OP_ATTACK, REG_WATT_LO, '0, ref_attacks(bd, 1'b0), {tag, " white att"});
      add_step(OP_ATTACK, REG_BATT_LO, '0, ref_attacks(bd, 1'b1), {tag, " black att"});
   endfunction

   function automatic void build_table();
      board_t open_b;
      board_t edge_b;
      board_t rnd;
      for (int r = 0; r < 8; r++)
         add_step(OP_READ, REG_ROW0 + r[7:0], '0, '0, $sformatf("reset row%0d", r));
      add_step(OP_READ, REG_STATUS, '0, '0, "reset status");
      add_step(OP_READ, REG_SCORE, '0, '0, "reset score");
      add_attack_checks('0, "reset");
      add_step(OP_WRITE, 8'd40, 32'hdead_beef, '0, "");   // Low bits alias row 0
      add_step(OP_READ, 8'd40, '0, '0, "unmapped read");
      add_step(OP_READ, REG_ROW0, '0, '0, "unmapped write ignored");
      add_step(OP_WRITE, REG_STATUS, 32'hffff_ffff, '0, "");
      add_step(OP_WRITE, REG_SCORE, 32'h0000_7fff, '0, "");
      add_step(OP_READ, REG_STATUS, '0, '0, "status read only");
      add_step(OP_READ, REG_SCORE, '0, '0, "score read only");
      rnd = random_board(1'b0);
      add_board(rnd);
      for (int r = 0; r < 8; r++)
         add_step(OP_READ, REG_ROW0 + r[7:0], '0, {32'd0, rnd[32*r +: 32]},
                  $sformatf("row%0d readback", r));
      add_step(OP_READ, 8'd40, '0, '0, "unmapped read loaded");
      add_step(OP_EVAL, REG_SCORE, '0, {32'd0, ref_score(rnd)}, "random 0 score");
      add_attack_checks(rnd, "random 0");
      open_b          = '0;
      open_b[31:0]    = 32'h4236_5324;                  // R N B Q K B N R from file a
      open_b[63:32]   = 32'h1111_1111;
      open_b[223:192] = 32'h9999_9999;
      open_b[255:224] = 32'hcabe_dbac;
      add_board(open_b);
      add_step(OP_EVAL, REG_SCORE, '0, '0, "opening score");
      add_attack_checks(open_b, "opening");
      edge_b          = '0;
      edge_b[32 +: 4]  = 4'd1;                          // a2
      edge_b[60 +: 4]  = 4'd1;                          // h2
      edge_b[124 +: 4] = 4'd1;                          // h4
      edge_b[236 +: 4] = 4'd1;                          // d8, no targets
      edge_b[192 +: 4] = 4'd9;                          // a7
      edge_b[220 +: 4] = 4'd9;                          // h7
      edge_b[128 +: 4] = 4'd9;                          // a5
      edge_b[16 +: 4]  = 4'd9;                          // e1, no targets
      add_board(edge_b);
      add_attack_checks(edge_b, "edge pawns");
      for (int k = 1; k < 4; k++)
      begin
         rnd = random_board(k == 3);
         add_board(rnd);
         add_step(OP_EVAL, REG_SCORE, '0, {32'd0, ref_score(rnd)},
                  $sformatf("random %0d score", k));
         add_attack_checks(rnd, $sformatf("random %0d", k));
      end
      add_step(OP_WRITE, REG_CTRL, 32'h8000_0000, '0, "");
      for (int r = 0; r < 8; r++)
         add_step(OP_READ, REG_ROW0 + r[7:0], '0, '0, $sformatf("soft reset row%0d", r));
      add_step(OP_READ, REG_STATUS, '0, '0, "soft reset status");
      add_step(OP_READ, REG_SCORE, '0, '0, "soft reset score");
      add_attack_checks('0, "soft reset");
   endfunction

   task automatic fail_timeout(input string what);
      $display("timeout waiting for %s", what);
      $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic check(input string name, input bitboard_t exp, input bitboard_t act);
      tests++;
      if (exp !== act)
      begin
         errors++;
         $display("error: %s expected %h actual %h", name, exp, act);
      end
      else
         $display("ok    %s", name);
   endtask

   task automatic settle();
      repeat (3) @(posedge clk);                        // Pulse, board, attack map
   endtask

   task automatic send_write(input reg_addr_t a, input reg_data_t d);
      int n;
      awaddr  <= {22'd0, a, 2'b00};
      wdata   <= d;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!awready && n < LIMIT);
      if (!awready)
         fail_timeout("write address ready");
      if (wready !== 1'b1)
         proto_errs++;                                  // Data ready pairs with address ready
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   task automatic wait_write_resp();
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!bvalid && n < LIMIT);
      if (!bvalid)
         fail_timeout("write response");
      if (bresp !== 2'b00)
         proto_errs++;
   endtask

   task automatic axi_write(input reg_addr_t a, input reg_data_t d);
      send_write(a, d);
      wait_write_resp();
   endtask

   task automatic axi_read(input reg_addr_t a, output reg_data_t d);
      int n;
      araddr  <= {22'd0, a, 2'b00};
      arvalid <= 1'b1;
      @(posedge clk);
      if (arready !== 1'b1)
         proto_errs++;
      arvalid <= 1'b0;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!rvalid && n < LIMIT);
      if (!rvalid)
         fail_timeout("read data");
      if (rresp !== 2'b00)
         proto_errs++;
      d = rdata;
   endtask

   task automatic run_eval(input string name, input bitboard_t exp);
      reg_data_t st;
      reg_data_t score;
      int        n;
      axi_write(REG_CTRL, 32'h1);
      settle();
      n = 0;
      do
      begin
         axi_read(REG_STATUS, st);
         n++;
      end
      while (!st[STATUS_VALID_BIT] && n < LIMIT);
      if (!st[STATUS_VALID_BIT])
         fail_timeout("evaluation result");
      axi_read(REG_SCORE, score);
      check(name, exp, {32'd0, score});
   endtask

   task automatic check_attacks(input reg_addr_t lo, input string name, input bitboard_t exp);
      reg_data_t w_lo;
      reg_data_t w_hi;
      axi_read(lo, w_lo);
      axi_read(lo + 8'd1, w_hi);
      check(name, exp, {w_hi, w_lo});
   endtask

   task automatic check_backpressure();
      logic      held;
      logic      early;
      reg_data_t word;
      held  = 1'b1;
      early = 1'b0;
      bready <= 1'b0;
      send_write(REG_ROW0 + 8'd3, 32'h1357_9bdf);
      wait_write_resp();
      awaddr  <= {22'd0, REG_ROW0 + 8'd4, 2'b00};     // Second write waits behind the response
      wdata   <= 32'h2468_ace0;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      repeat (6)
      begin
         @(posedge clk);
         held  = held & bvalid;
         early = early | awready;
      end
      check("bvalid held while stalled", 64'd1, {63'd0, held});
      check("no accept while stalled", 64'd0, {63'd0, early});
      bready <= 1'b1;
      send_write(REG_ROW0 + 8'd4, 32'h2468_ace0);
      wait_write_resp();
      settle();
      axi_read(REG_ROW0 + 8'd3, word);
      check("stalled write row3", 64'h1357_9bdf, {32'd0, word});
      axi_read(REG_ROW0 + 8'd4, word);
      check("second write row4", 64'h2468_ace0, {32'd0, word});
   endtask

   initial
   begin
      reg_data_t   word;
      step_t       st;
      rst     = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b1;
      void'($urandom(seed));
      build_table();
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check("idle after reset", 64'd0, {60'd0, awready, wready, bvalid, rvalid});
      foreach (steps[i])
      begin
         st = steps[i];
         case (st.op)
            OP_WRITE:
            begin
               axi_write(st.addr, st.data);
               settle();
            end
            OP_READ:
            begin
               axi_read(st.addr, word);
               check(names[i], st.exp, {32'd0, word});
            end
            OP_EVAL:
               run_eval(names[i], st.exp);
            default:
               check_attacks(st.addr, names[i], st.exp);
         endcase
      end
      check_backpressure();
      check("axi ready and response codes", 64'd0, {32'd0, proto_errs});
      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
chess_pkg.sv
axil_write.sv
ctrl_regs.sv
material_eval.sv
pawn_attacks.sv
chess_core_top.sv
chess_tb.sv
